/* common/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// address and pc width
`define FETCH_ADDR_W 32

// one instruction word
`define FETCH_INSTR_W 32

// memory response, two words per fetch
`define FETCH_PAIR_W 64

// boot rom entry after reset
`define FETCH_RESET_PC 32'hbfc0_0000

// two instructions per cycle
`define FETCH_STEP 32'd8

// second slot sits one word above the first
`define FETCH_SLOT_OFFSET 32'd4

`endif

/* common/fetch_pkg.sv */
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    // one redirect request from a downstream stage
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] target;
    } redirect_t;

    // instruction memory request
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] addr;
    } imem_req_t;

    // one fetched instruction
    typedef struct packed {
        logic                      valid;
        logic [`FETCH_ADDR_W-1:0]  pc;
        logic [`FETCH_INSTR_W-1:0] instr;
        logic                      addr_exc;
    } fetch_slot_t;

    // slot0 is the older instruction
    typedef struct packed {
        fetch_slot_t slot1;
        fetch_slot_t slot0;
    } fetch_pair_t;

    // redirect held while fetch is stalled
    // encoded so a larger value means a higher priority class
    typedef enum logic [1:0] {
        HOLD_IDLE   = 2'd0,
        HOLD_JR     = 2'd1,
        HOLD_BRANCH = 2'd2,
        HOLD_EXC    = 2'd3
    } hold_state_e;

endpackage

`default_nettype wire

/* fetch/fetch_pair_buffer.sv */
`default_nettype none

`include "fetch_macros.svh"

module fetch_pair_buffer (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     i_stall_f,
    input  wire logic                     i_flush,
    input  wire logic [`FETCH_ADDR_W-1:0] i_pc,
    input  wire logic [`FETCH_PAIR_W-1:0] i_imem_data,
    output fetch_pkg::fetch_pair_t        o_fetch
);

    // f1 stage, address sent and waiting for its pair
    logic                     f1_valid;
    logic [`FETCH_ADDR_W-1:0] f1_pc;
    logic                     f1_misaligned;

    // response that came back while f1 could not move
    logic                     resp_saved;
    logic [`FETCH_PAIR_W-1:0] resp_save;
    logic [`FETCH_PAIR_W-1:0] resp_data;

    fetch_pkg::fetch_pair_t   pair_nxt;
    fetch_pkg::fetch_pair_t   f2_pair;

    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            f1_valid <= 1'b0;
        end else if (!i_stall_f) begin
            f1_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall_f) begin
            f1_pc         <= i_pc;
            f1_misaligned <= (i_pc[1:0] != 2'b00);
        end
    end

    // memory answers once, one cycle after accepting, so keep the first one
    always_ff @(posedge clk) begin
        if (reset || !i_stall_f) begin
            resp_saved <= 1'b0;
        end else if (f1_valid && !i_flush && !resp_saved) begin
            resp_saved <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_stall_f && f1_valid && !resp_saved) begin
            resp_save <= i_imem_data;
        end
    end

    assign resp_data = resp_saved ? resp_save : i_imem_data;

    // split the pair, low word belongs to the f1 pc
    always_comb begin
        pair_nxt.slot0.valid    = f1_valid;
        pair_nxt.slot0.pc       = f1_pc;
        pair_nxt.slot0.instr    = resp_data[`FETCH_INSTR_W-1:0];
        pair_nxt.slot0.addr_exc = f1_misaligned;

        pair_nxt.slot1.valid    = f1_valid && !f1_misaligned;
        pair_nxt.slot1.pc       = f1_pc + `FETCH_SLOT_OFFSET;
        pair_nxt.slot1.instr    = resp_data[`FETCH_PAIR_W-1:`FETCH_INSTR_W];
        pair_nxt.slot1.addr_exc = 1'b0;

        // bad pc never reached memory
        if (f1_misaligned) begin
            pair_nxt.slot0.instr = '0;
            pair_nxt.slot1.instr = '0;
        end
    end

    // f2 payload, loads only on a free cycle
    always_ff @(posedge clk) begin
        if (!i_stall_f) begin
            f2_pair <= pair_nxt;
        end
        // flush wins even under stall
        if (reset || i_flush) begin
            f2_pair.slot0.valid <= 1'b0;
            f2_pair.slot1.valid <= 1'b0;
        end
    end

    assign o_fetch = f2_pair;

endmodule

`default_nettype wire

/* fetch/fetch_unit.sv */
`default_nettype none

`include "fetch_macros.svh"

module fetch_unit (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     i_stall,
    input  wire logic                     i_imem_addr_ok,
    input  wire logic [`FETCH_PAIR_W-1:0] i_imem_data,
    input  wire fetch_pkg::redirect_t     i_exc_redirect,
    input  wire fetch_pkg::redirect_t     i_branch_redirect,
    input  wire fetch_pkg::redirect_t     i_jr_redirect,
    output fetch_pkg::imem_req_t          o_imem_req,
    output fetch_pkg::fetch_pair_t        o_fetch
);

    logic                     stall_f;
    logic                     flush;
    logic [`FETCH_ADDR_W-1:0] pc;
    fetch_pkg::redirect_t     load;

    // only word aligned addresses go out to memory
    assign o_imem_req.valid = (pc[1:0] == 2'b00);
    assign o_imem_req.addr  = pc;

    // downstream back-pressure or memory not taking the address
    assign stall_f = i_stall || (o_imem_req.valid && !i_imem_addr_ok);

    redirect_hold_fsm redirect_hold_fsm_i (
        .clk               (clk),
        .reset             (reset),
        .i_stall_f         (stall_f),
        .i_exc_redirect    (i_exc_redirect),
        .i_branch_redirect (i_branch_redirect),
        .i_jr_redirect     (i_jr_redirect),
        .o_load            (load),
        .o_flush           (flush)
    );

    pc_counter pc_counter_i (
        .clk       (clk),
        .reset     (reset),
        .i_stall_f (stall_f),
        .i_load    (load),
        .o_pc      (pc)
    );

    // f1 and f2 registers plus the response save buffer
    fetch_pair_buffer fetch_pair_buffer_i (
        .clk         (clk),
        .reset       (reset),
        .i_stall_f   (stall_f),
        .i_flush     (flush),
        .i_pc        (pc),
        .i_imem_data (i_imem_data),
        .o_fetch     (o_fetch)
    );

endmodule

`default_nettype wire

/* fetch/pc_counter.sv */
`default_nettype none

`include "fetch_macros.svh"

module pc_counter (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     i_stall_f,
    input  wire fetch_pkg::redirect_t     i_load,
    output logic [`FETCH_ADDR_W-1:0]      o_pc
);

    logic [`FETCH_ADDR_W-1:0] pc_nxt;

    // redirect target first, else the next pair
    always_comb begin
        if (i_load.valid) begin
            pc_nxt = i_load.target;
        end else begin
            pc_nxt = o_pc + `FETCH_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_pc <= `FETCH_RESET_PC;
        end else if (!i_stall_f) begin
            o_pc <= pc_nxt;
        end
    end

endmodule

`default_nettype wire

/* fetch/redirect_hold_fsm.sv */
`default_nettype none

`include "fetch_macros.svh"

module redirect_hold_fsm (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 i_stall_f,
    input  wire fetch_pkg::redirect_t i_exc_redirect,
    input  wire fetch_pkg::redirect_t i_branch_redirect,
    input  wire fetch_pkg::redirect_t i_jr_redirect,
    output fetch_pkg::redirect_t      o_load,
    output logic                      o_flush
);

    fetch_pkg::hold_state_e   hold_state;
    fetch_pkg::hold_state_e   hold_state_nxt;
    fetch_pkg::hold_state_e   live_class;
    logic [`FETCH_ADDR_W-1:0] live_target;
    logic [`FETCH_ADDR_W-1:0] held_target;
    logic                     live_any;
    logic                     held_any;
    logic                     take_held;
    logic                     capture;

    // strongest redirect arriving this cycle
    always_comb begin
        live_class  = fetch_pkg::HOLD_IDLE;
        live_target = '0;
        if (i_exc_redirect.valid) begin
            live_class  = fetch_pkg::HOLD_EXC;
            live_target = i_exc_redirect.target;
        end else if (i_branch_redirect.valid) begin
            live_class  = fetch_pkg::HOLD_BRANCH;
            live_target = i_branch_redirect.target;
        end else if (i_jr_redirect.valid) begin
            live_class  = fetch_pkg::HOLD_JR;
            live_target = i_jr_redirect.target;
        end
    end

    assign live_any = (live_class != fetch_pkg::HOLD_IDLE);
    assign held_any = (hold_state != fetch_pkg::HOLD_IDLE);

    // held entry beats a live one of the same class
    assign take_held = held_any && (hold_state >= live_class);

    // equal class overwrites, so the latest target of a class wins
    assign capture = i_stall_f && live_any && (live_class >= hold_state);

    always_comb begin
        hold_state_nxt = hold_state;
        if (!i_stall_f) begin
            // first free cycle applies whatever was held
            hold_state_nxt = fetch_pkg::HOLD_IDLE;
        end else if (capture) begin
            hold_state_nxt = live_class;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_state <= fetch_pkg::HOLD_IDLE;
        end else begin
            hold_state <= hold_state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_target <= live_target;
        end
    end

    // pc_counter ignores the load while stalled
    assign o_load.valid  = held_any || live_any;
    assign o_load.target = take_held ? held_target : live_target;

    // kill younger fetches on arrival and again when the held target lands
    assign o_flush = live_any || (held_any && !i_stall_f);

endmodule

`default_nettype wire

/* test/fetch_cases.txt */
# case <name> <cycles> <random address refusals 0 or 1> ... end
# exc|br|jr <cycle> <target hex>, stall <first> <last>, pairs <first pc hex> <count>
case seq 20 0
pairs bfc00000 4
end
case branch 25 0
br 4 80001000
pairs bfc00000 3
pairs 80001000 2
end
case exc_and_branch 25 0
exc 4 80000180
br 4 80001000
pairs bfc00000 3
pairs 80000180 2
end
case exc_over_held_branch 30 0
stall 4 7
br 5 80001000
exc 6 80000180
pairs bfc00000 2
pairs 80000180 2
end
case branch_over_held_jr 30 0
stall 4 7
jr 5 80002000
br 6 80001000
pairs bfc00000 2
pairs 80001000 2
end
case held_exc_drops_branch 30 0
stall 4 7
exc 5 80000180
br 6 80001000
pairs bfc00000 2
pairs 80000180 2
end
case misaligned 25 0
br 4 80001002
pairs bfc00000 3
pairs 80001002 2
end
case random_refusals 80 1
stall 10 13
pairs bfc00000 8
end

/* test/fetch_chk.sv */
`default_nettype none

`include "fetch_macros.svh"

module fetch_chk (
    input wire logic                     clk,
    input wire logic                     reset,
    input wire logic                     i_flush,
    input wire fetch_pkg::imem_req_t     i_imem_req,
    input wire fetch_pkg::fetch_pair_t   i_fetch
);

    timeunit 1ns;
    timeprecision 1ps;

    logic any_valid;
    // assertion failures so far
    int   fail_count = 0;

    assign any_valid = i_fetch.slot0.valid || i_fetch.slot1.valid;

    // both stages come out of reset empty
    assert property (@(posedge clk) reset |=> !any_valid)
        else begin
            $error("valid fetch slot in the cycle after reset");
            fail_count = fail_count + 1;
        end

    // memory never sees a misaligned request
    assert property (@(posedge clk) disable iff (reset)
        i_imem_req.valid |-> (i_imem_req.addr[1:0] == 2'b00))
        else begin
            $error("imem request valid with misaligned address %h", i_imem_req.addr);
            fail_count = fail_count + 1;
        end

    assert property (@(posedge clk) disable iff (reset) i_flush |=> !any_valid)
        else begin
            $error("fetch slot still valid on the edge after a flush");
            fail_count = fail_count + 1;
        end

endmodule

bind fetch_unit fetch_chk fetch_chk_i (
    .clk        (clk),
    .reset      (reset),
    .i_flush    (flush),
    .i_imem_req (o_imem_req),
    .i_fetch    (o_fetch)
);

`default_nettype wire

/* test/fetch_tb.sv */
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                     clk;
    logic                     reset;
    logic                     i_stall;
    logic                     i_imem_addr_ok;
    logic [`FETCH_PAIR_W-1:0] i_imem_data = '0;
    fetch_pkg::redirect_t     exc_r;
    fetch_pkg::redirect_t     br_r;
    fetch_pkg::redirect_t     jr_r;
    fetch_pkg::imem_req_t     imem_req;
    fetch_pkg::fetch_pair_t   fetch_out;

    // per case stimulus indexed by cycle after reset
    logic                     exc_v [0:255];
    logic [`FETCH_ADDR_W-1:0] exc_t [0:255];
    logic                     br_v [0:255];
    logic [`FETCH_ADDR_W-1:0] br_t [0:255];
    logic                     jr_v [0:255];
    logic [`FETCH_ADDR_W-1:0] jr_t [0:255];
    logic                     stall_v [0:255];
    logic [`FETCH_ADDR_W-1:0] exp_pc [$];
    reg   [8*24-1:0]          case_name;
    int                       case_len;
    logic                     case_rand;

    int          errors = 0;
    int          case_errors;
    int          cases_run = 0;
    int          cases_failed = 0;
    int          checked;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] rng = 32'h26c86e20;

    fetch_unit dut_i (
        .clk               (clk),
        .reset             (reset),
        .i_stall           (i_stall),
        .i_imem_addr_ok    (i_imem_addr_ok),
        .i_imem_data       (i_imem_data),
        .i_exc_redirect    (exc_r),
        .i_branch_redirect (br_r),
        .i_jr_redirect     (jr_r),
        .o_imem_req        (imem_req),
        .o_fetch           (fetch_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory returns the accepted address pair one cycle later and junk otherwise
    always @(posedge clk) begin
        if (imem_req.valid && i_imem_addr_ok) begin
            i_imem_data <= {imem_req.addr + 32'd4, imem_req.addr};
        end else begin
            i_imem_data <= {~imem_req.addr, imem_req.addr ^ 32'h5a5a_5a5a};
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, what, got, exp);
            errors = errors + 1;
            case_errors = case_errors + 1;
        end
    endtask

    task automatic clear_inputs();
        i_stall        <= 1'b0;
        i_imem_addr_ok <= 1'b1;
        exc_r          <= '0;
        br_r           <= '0;
        jr_r           <= '0;
    endtask

    task automatic clear_case_data();
        for (int i = 0; i < 256; i++) begin
            exc_v[i]   = 1'b0;
            exc_t[i]   = '0;
            br_v[i]    = 1'b0;
            br_t[i]    = '0;
            jr_v[i]    = 1'b0;
            jr_t[i]    = '0;
            stall_v[i] = 1'b0;
        end
        exp_pc.delete();
    endtask

    task automatic drive_cycle(input int cyc);
        exc_r   <= {exc_v[cyc], exc_t[cyc]};
        br_r    <= {br_v[cyc], br_t[cyc]};
        jr_r    <= {jr_v[cyc], jr_t[cyc]};
        i_stall <= stall_v[cyc];
        if (case_rand) begin
            rng = xorshift32(rng);
            i_imem_addr_ok <= (rng[1:0] != 2'b00);
        end else begin
            i_imem_addr_ok <= 1'b1;
        end
    endtask

    // memory data equals the address and a misaligned pc gets a zero word
    task automatic take_slot(input fetch_pkg::fetch_slot_t s);
        logic [31:0] pc_exp;
        logic        mis;
        if (exp_pc.size() == 0) begin
            $display("case %0s: extra valid slot with pc %h", case_name, s.pc);
            errors = errors + 1;
            case_errors = case_errors + 1;
            return;
        end
        pc_exp = exp_pc.pop_front();
        mis = (pc_exp[1:0] != 2'b00);
        check_value(s.pc, pc_exp, "slot pc");
        check_value(s.instr, mis ? 32'd0 : pc_exp, "slot instruction");
        check_value({31'd0, s.addr_exc}, {31'd0, mis}, "address exception flag");
        checked = checked + 1;
    endtask

    task automatic run_case();
        int   cyc;
        logic stall_f;
        case_errors = 0;
        checked = 0;
        reset <= 1'b1;
        clear_inputs();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        cyc = 0;
        while (cyc < case_len && exp_pc.size() != 0) begin
            drive_cycle(cyc);
            @(negedge clk);
            // a pair counts once on the cycle fetch advances past it
            stall_f = i_stall || (imem_req.valid && !i_imem_addr_ok);
            if (!stall_f) begin
                if (fetch_out.slot0.valid) begin
                    take_slot(fetch_out.slot0);
                    if (fetch_out.slot0.addr_exc) begin
                        check_value({31'd0, fetch_out.slot1.valid}, 32'd0,
                                    "slot 1 valid beside an address exception");
                    end
                end
                if (fetch_out.slot1.valid) begin
                    take_slot(fetch_out.slot1);
                end
            end
            @(posedge clk);
            cyc = cyc + 1;
        end
        if (exp_pc.size() != 0) begin
            $display("case %0s: %0d expected slots never arrived", case_name, exp_pc.size());
            errors = errors + 1;
            case_errors = case_errors + 1;
        end
        cases_run = cases_run + 1;
        if (case_errors != 0) begin
            cases_failed = cases_failed + 1;
        end
        $display("case %0s: %0d slots checked, %0d errors", case_name, checked, case_errors);
    endtask

    initial begin
        int              fd;
        int              total;
        int              a;
        logic [31:0]     b;
        reg [8*120-1:0]  line;
        reg [8*24-1:0]   cmd;
        reset = 1'b1;
        i_stall = 1'b0;
        i_imem_addr_ok = 1'b1;
        exc_r = '0;
        br_r = '0;
        jr_r = '0;
        total = 0;
        fd = $fopen("test/fetch_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open test/fetch_cases.txt");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            // first pass only sums case lengths for the cycle limit
            while (!$feof(fd)) begin
                line = '0;
                cmd = '0;
                void'($fgets(line, fd));
                if ($sscanf(line, "%s %s %d", cmd, case_name, a) == 3 && cmd == "case") begin
                    total = total + a;
                end
            end
            $fclose(fd);
            cycle_limit = total * 4;
            fd = $fopen("test/fetch_cases.txt", "r");
            @(posedge clk);
            while (!$feof(fd)) begin
                line = '0;
                cmd = '0;
                void'($fgets(line, fd));
                void'($sscanf(line, "%s", cmd));
                if (cmd == "case") begin
                    void'($sscanf(line, "%s %s %d %d", cmd, case_name, case_len, a));
                    case_rand = (a != 0);
                    clear_case_data();
                end else if (cmd == "exc" || cmd == "br" || cmd == "jr") begin
                    void'($sscanf(line, "%s %d %h", cmd, a, b));
                    if (cmd == "exc") begin
                        exc_v[a] = 1'b1;
                        exc_t[a] = b;
                    end else if (cmd == "br") begin
                        br_v[a] = 1'b1;
                        br_t[a] = b;
                    end else begin
                        jr_v[a] = 1'b1;
                        jr_t[a] = b;
                    end
                end else if (cmd == "stall") begin
                    void'($sscanf(line, "%s %d %d", cmd, a, b));
                    for (int i = a; i <= b; i++) begin
                        stall_v[i] = 1'b1;
                    end
                end else if (cmd == "pairs") begin
                    void'($sscanf(line, "%s %h %d", cmd, b, a));
                    for (int i = 0; i < a; i++) begin
                        exp_pc.push_back(b);
                        if (b[1:0] == 2'b00) begin
                            exp_pc.push_back(b + `FETCH_SLOT_OFFSET);
                        end
                        b = b + `FETCH_STEP;
                    end
                end else if (cmd == "end") begin
                    run_case();
                end
            end
            $fclose(fd);
            $display("cases %0d, failed %0d, check errors %0d, assertion failures %0d",
                     cases_run, cases_failed, errors, dut_i.fetch_chk_i.fail_count);
            if (errors == 0 && dut_i.fetch_chk_i.fail_count == 0 && cases_run != 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/fetch_pkg.sv
fetch/redirect_hold_fsm.sv
fetch/pc_counter.sv
fetch/fetch_pair_buffer.sv
fetch/fetch_unit.sv
test/fetch_chk.sv
test/fetch_tb.sv
